/* src/buf_pkg.sv */
package buf_pkg;

    // page geometry of one bank
    localparam int page_w         = 11;
    localparam int num_pages      = 2048;
    localparam int words_per_page = 8;
    localparam int word_sel_w     = 3;
    localparam int word_w         = 16;

    // one check byte per page
    localparam int check_w = 8;

    // global address = bank index over page number
    localparam int bank_w = 5;
    localparam int addr_w = 16;

    // wishbone register map, word offsets
    localparam int reg_adr_w = 2;

    typedef enum logic [reg_adr_w-1:0] {
        reg_ctrl      = 2'd0,
        reg_low_water = 2'd1,
        reg_free      = 2'd2,
        reg_pkt_count = 2'd3
    } reg_addr_e;

endpackage

/* src/pkt_pkg.sv */
package pkt_pkg;

    // header word fields
    localparam int dest_lsb  = 0;
    localparam int dest_w    = 4;
    localparam int prior_lsb = 4;
    localparam int prior_w   = 3;

    // length counts pages minus one
    localparam int len_lsb = 10;
    localparam int len_w   = 6;

    // write path: waiting for header, inside first page, later pages
    typedef enum logic [1:0] {
        wr_idle,
        wr_first_page,
        wr_body
    } wr_state_e;

endpackage

/* src/page_free_list.sv */
module page_free_list (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       alloc_pop,
    input  logic                       free_push,
    input  logic [buf_pkg::page_w-1:0] free_page,
    output logic [buf_pkg::page_w-1:0] alloc_page,
    output logic                       list_ready
);
    import buf_pkg::*;

    // circular list of free page numbers
    logic [page_w-1:0] list_mem [num_pages];

    logic [page_w-1:0] head_ptr;
    logic [page_w-1:0] tail_ptr;

    // fill counter, one extra bit to mark completion
    logic [page_w:0]   fill_cnt;

    logic              list_wr;
    logic [page_w-1:0] list_din;

    assign list_ready = (fill_cnt == (page_w + 1)'(num_pages));

    // fill first, then returned pages go to the back
    always_comb begin
        list_wr  = !list_ready || free_push;
        list_din = list_ready ? free_page : fill_cnt[page_w-1:0];
    end

    always_ff @(posedge clk) begin
        if (list_wr) begin
            list_mem[tail_ptr] <= list_din;
        end
    end

    // front entry seen directly, so the tail page is known at the header
    assign alloc_page = list_mem[head_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt <= '0;
            tail_ptr <= '0;
        end else begin
            if (list_wr) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (!list_ready) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // pointers wrap over all pages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end else if (alloc_pop) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

endmodule

/* src/page_check_gen.sv */
module page_check_gen (
    input  logic [buf_pkg::words_per_page-1:0][buf_pkg::word_w-1:0] page_words,
    output logic [buf_pkg::check_w-1:0]                             check
);
    import buf_pkg::*;

    // running xor of all words in the page
    logic [word_w-1:0] fold;

    always_comb begin
        fold = '0;
        for (int i = 0; i < words_per_page; i++) begin
            fold = fold ^ page_words[i];
        end
        // upper byte against lower byte
        check = fold[word_w-1 -: check_w] ^ fold[check_w-1:0];
    end

endmodule

/* src/buf_regs.sv */
module buf_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [buf_pkg::reg_adr_w-1:0] wb_adr,
    input  logic [buf_pkg::word_w-1:0]    wb_dat_w,
    output logic [buf_pkg::word_w-1:0]    wb_dat_r,
    output logic                          wb_ack,
    input  logic [buf_pkg::page_w-1:0]    free_space,
    input  logic                          join_req,
    output logic [buf_pkg::bank_w-1:0]    bank_idx,
    output logic [buf_pkg::page_w-1:0]    low_water,
    output logic                          almost_full
);
    import buf_pkg::*;

    logic              bus_req;
    reg_addr_e         reg_sel;
    logic [word_w-1:0] pkt_count;

    // new cycle only while no ack is out, gives a one-cycle ack
    assign bus_req = wb_cyc && wb_stb && !wb_ack;
    assign reg_sel = reg_addr_e'(wb_adr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= bus_req;
        end
    end

    // writable registers, read-only offsets fall through
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bank_idx  <= '0;
            low_water <= '0;
        end else if (bus_req && wb_we) begin
            case (reg_sel)
                reg_ctrl:      bank_idx  <= wb_dat_w[bank_w-1:0];
                reg_low_water: low_water <= wb_dat_w[page_w-1:0];
                default:       ;
            endcase
        end
    end

    // read data registered with the ack
    always_ff @(posedge clk) begin
        if (bus_req && !wb_we) begin
            case (reg_sel)
                reg_ctrl:      wb_dat_r <= word_w'(bank_idx);
                reg_low_water: wb_dat_r <= word_w'(low_water);
                reg_free:      wb_dat_r <= word_w'(free_space);
                reg_pkt_count: wb_dat_r <= pkt_count;
                default:       wb_dat_r <= '0;
            endcase
        end
    end

    // packets joined since reset, wraps
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_count <= '0;
        end else if (join_req) begin
            pkt_count <= pkt_count + 1'b1;
        end
    end

    assign almost_full = (free_space < low_water);

endmodule

/* src/packet_buffer.sv */
module packet_buffer (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  wr_vld,
    input  logic [buf_pkg::word_w-1:0]                            wr_data,
    input  logic                                                  wr_eop,
    output logic                                                  join_req,
    output logic [pkt_pkg::dest_w-1:0]                            join_dest,
    output logic [pkt_pkg::prior_w-1:0]                           join_prior,
    output logic [buf_pkg::addr_w-1:0]                            join_head,
    output logic [buf_pkg::addr_w-1:0]                            join_tail,
    input  logic                                                  cat_en,
    input  logic [buf_pkg::page_w-1:0]                            cat_head,
    input  logic [buf_pkg::addr_w-1:0]                            cat_tail,
    input  logic                                                  rd_start,
    input  logic [buf_pkg::page_w-1:0]                            rd_page,
    output logic                                                  rd_vld,
    output logic [buf_pkg::word_w-1:0]                            rd_data,
    output logic [buf_pkg::addr_w-1:0]                            rd_next_page,
    output logic [buf_pkg::check_w-1:0]                           rd_check,
    input  logic [buf_pkg::bank_w-1:0]                            bank_idx,
    input  logic [buf_pkg::page_w-1:0]                            alloc_page,
    output logic                                                  alloc_pop,
    output logic                                                  free_push,
    output logic [buf_pkg::page_w-1:0]                            free_page,
    output logic [buf_pkg::words_per_page-1:0][buf_pkg::word_w-1:0] page_words,
    input  logic [buf_pkg::check_w-1:0]                           page_check,
    output logic [buf_pkg::page_w-1:0]                            free_space
);
    import buf_pkg::*;
    import pkt_pkg::*;

    // data sram, jump table, check bytes
    logic [word_w-1:0]  data_mem  [num_pages * words_per_page];
    logic [addr_w-1:0]  jump_mem  [num_pages];
    logic [check_w-1:0] check_mem [num_pages];

    wr_state_e               wr_state;
    logic [word_sel_w-1:0]   wr_cnt;
    logic [page_w-1:0]       wr_page;
    logic [page_w-1:0]       cur_page;
    logic                    hdr_seen;
    logic                    last_word;
    logic                    link_en;
    logic [len_w-1:0]        hdr_len;
    logic [len_w-1:0]        pkt_len;
    logic                    ck_wr;
    logic [page_w-1:0]       ck_page;
    logic [page_w-1:0]       space_dec;
    logic [word_sel_w:0]     rd_cnt;
    logic                    rd_busy;
    logic [page_w-1:0]       rd_page_q;
    logic [page_w+word_sel_w-1:0] rd_addr;

    // header is word 0 of the first page
    assign hdr_seen  = wr_vld && (wr_state == wr_idle);
    assign hdr_len   = wr_data[len_lsb +: len_w];
    assign last_word = (wr_cnt == word_sel_w'(words_per_page - 1));

    // first page comes straight off the free list at the header
    assign cur_page = hdr_seen ? alloc_page : wr_page;

    // next page taken at the header and at each full page inside the packet
    assign alloc_pop = hdr_seen || (wr_vld && last_word && !wr_eop);

    // no link out of the tail page
    assign link_en = wr_vld && last_word && !wr_eop && (wr_page != join_tail[page_w-1:0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: begin
                    if (wr_vld && !wr_eop) begin
                        wr_state <= wr_first_page;
                    end
                end
                wr_first_page: begin
                    if (wr_vld && wr_eop) begin
                        wr_state <= wr_idle;
                    end else if (wr_vld && last_word) begin
                        wr_state <= wr_body;
                    end
                end
                default: begin
                    if (wr_vld && wr_eop) begin
                        wr_state <= wr_idle;
                    end
                end
            endcase
        end
    end

    // word position, back to 0 after eop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (wr_vld) begin
            wr_cnt <= wr_eop ? '0 : wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_pop) begin
            wr_page <= alloc_page;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            data_mem[{cur_page, wr_cnt}] <= wr_data;
        end
        if (rd_start || rd_busy) begin
            rd_data <= data_mem[rd_addr];
        end
    end

    // page copy for the check byte, rest of page zeroed on word 0
    always_ff @(posedge clk) begin
        if (wr_vld) begin
            for (int i = 0; i < words_per_page; i++) begin
                if (i == int'(wr_cnt)) begin
                    page_words[i] <= wr_data;
                end else if (wr_cnt == '0) begin
                    page_words[i] <= '0;
                end
            end
        end
    end

    // check byte written the cycle after the page closes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ck_wr <= 1'b0;
        end else begin
            ck_wr <= wr_vld && (wr_eop || last_word);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_vld) begin
            ck_page <= cur_page;
        end
        if (ck_wr) begin
            check_mem[ck_page] <= page_check;
        end
        if (rd_start) begin
            rd_check <= check_mem[rd_page];
        end
    end

    // splice from the queue manager wins over the page link
    always_ff @(posedge clk) begin
        if (cat_en) begin
            jump_mem[cat_head] <= cat_tail;
        end else if (link_en) begin
            jump_mem[wr_page] <= {bank_idx, alloc_page};
        end
        if (rd_start) begin
            rd_next_page <= jump_mem[rd_page];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            join_req <= 1'b0;
        end else begin
            join_req <= hdr_seen;
        end
    end

    // tail assumes consecutive list entries from the head page
    always_ff @(posedge clk) begin
        if (hdr_seen) begin
            join_dest  <= wr_data[dest_lsb +: dest_w];
            join_prior <= wr_data[prior_lsb +: prior_w];
            join_head  <= {bank_idx, alloc_page};
            join_tail  <= {bank_idx, alloc_page + page_w'(hdr_len)};
            pkt_len    <= hdr_len;
        end
    end

    // read sequencer, counter parks at words_per_page when idle
    assign rd_busy = (rd_cnt != (word_sel_w + 1)'(words_per_page));
    assign rd_addr = rd_start ? {rd_page, word_sel_w'(0)} : {rd_page_q, rd_cnt[word_sel_w-1:0]};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_cnt <= (word_sel_w + 1)'(words_per_page);
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= rd_start || rd_busy;
            if (rd_start) begin
                rd_cnt <= (word_sel_w + 1)'(1);
            end else if (rd_busy) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_start) begin
            rd_page_q <= rd_page;
        end
    end

    // page goes back to the list as soon as its read starts
    assign free_push = rd_start;
    assign free_page = rd_page;

    // join takes length plus one pages, each read returns one
    assign space_dec = join_req ? page_w'(pkt_len) + page_w'(1) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_space <= page_w'(num_pages - 1);
        end else begin
            free_space <= free_space - space_dec + page_w'(rd_start);
        end
    end

endmodule

/* src/buf_top.sv */
module buf_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_vld,
    input  logic [buf_pkg::word_w-1:0]    wr_data,
    input  logic                          wr_eop,
    output logic                          join_req,
    output logic [pkt_pkg::dest_w-1:0]    join_dest,
    output logic [pkt_pkg::prior_w-1:0]   join_prior,
    output logic [buf_pkg::addr_w-1:0]    join_head,
    output logic [buf_pkg::addr_w-1:0]    join_tail,
    input  logic                          cat_en,
    input  logic [buf_pkg::page_w-1:0]    cat_head,
    input  logic [buf_pkg::addr_w-1:0]    cat_tail,
    input  logic                          rd_start,
    input  logic [buf_pkg::page_w-1:0]    rd_page,
    output logic                          rd_vld,
    output logic [buf_pkg::word_w-1:0]    rd_data,
    output logic [buf_pkg::addr_w-1:0]    rd_next_page,
    output logic [buf_pkg::check_w-1:0]   rd_check,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [buf_pkg::reg_adr_w-1:0] wb_adr,
    input  logic [buf_pkg::word_w-1:0]    wb_dat_w,
    output logic [buf_pkg::word_w-1:0]    wb_dat_r,
    output logic                          wb_ack,
    output logic [buf_pkg::page_w-1:0]    free_space,
    output logic                          almost_full,
    output logic                          list_ready
);
    import buf_pkg::*;

    logic [bank_w-1:0]                     bank_idx;
    logic [page_w-1:0]                     alloc_page;
    logic                                  alloc_pop;
    logic                                  free_push;
    logic [page_w-1:0]                     free_page;
    logic [words_per_page-1:0][word_w-1:0] page_words;
    logic [check_w-1:0]                    page_check;

    // threshold is compared inside the register block
    buf_regs u_buf_regs (
        .clk, .rst_n,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .free_space, .join_req, .bank_idx,
        .low_water   (),
        .almost_full
    );

    packet_buffer u_packet_buffer (
        .clk, .rst_n,
        .wr_vld, .wr_data, .wr_eop,
        .join_req, .join_dest, .join_prior, .join_head, .join_tail,
        .cat_en, .cat_head, .cat_tail,
        .rd_start, .rd_page, .rd_vld, .rd_data, .rd_next_page, .rd_check,
        .bank_idx, .alloc_page, .alloc_pop, .free_push, .free_page,
        .page_words, .page_check, .free_space
    );

    page_free_list u_page_free_list (
        .clk, .rst_n, .alloc_pop, .free_push, .free_page, .alloc_page, .list_ready
    );

    page_check_gen u_page_check_gen (
        .page_words,
        .check      (page_check)
    );

endmodule

/* verification/buf_tb.sv */
module buf_tb;
    import buf_pkg::*;
    import pkt_pkg::*;

    // 75 pages per pass so 28 passes run the free list past one full wrap
    localparam int n_passes     = 28;
    localparam int tc_bank      = 3;
    localparam int tc_low_water = 2040;

    logic                           clk;
    logic                           rst_n;
    logic                           wr_vld;
    logic [word_w-1:0]              wr_data;
    logic                           wr_eop;
    logic                           join_req;
    logic [dest_w-1:0]              join_dest;
    logic [prior_w-1:0]             join_prior;
    logic [addr_w-1:0]              join_head;
    logic [addr_w-1:0]              join_tail;
    logic                           cat_en;
    logic [page_w-1:0]              cat_head;
    logic [addr_w-1:0]              cat_tail;
    logic                           rd_start;
    logic [page_w-1:0]              rd_page;
    logic                           rd_vld;
    logic [word_w-1:0]              rd_data;
    logic [addr_w-1:0]              rd_next_page;
    logic [check_w-1:0]             rd_check;
    logic                           wb_cyc;
    logic                           wb_stb;
    logic                           wb_we;
    logic [reg_adr_w-1:0]           wb_adr;
    logic [word_w-1:0]              wb_dat_w;
    logic [word_w-1:0]              wb_dat_r;
    logic                           wb_ack;
    logic [page_w-1:0]              free_space;
    logic                           almost_full;
    logic                           list_ready;

    // packet table
    string tc_name  [$];
    int    tc_dest  [$];
    int    tc_prior [$];
    int    tc_pages [$];
    int    tc_eop   [$];
    int    tc_cat   [$];

    // reference model of free list order, page contents and jump table
    int                free_q     [$];
    int                alloc_log  [$];
    int                first_idx  [$];
    int                model_free;
    int                model_pkts;
    logic [word_w-1:0] mem_model  [];
    bit                word_known [];
    logic [addr_w-1:0] jump_model [];
    bit                jump_known [];

    buf_top u_buf_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic add_entry(input string name, input int dest, input int prior,
                             input int pages, input int eop, input int cat);
        tc_name.push_back(name);
        tc_dest.push_back(dest);
        tc_prior.push_back(prior);
        tc_pages.push_back(pages);
        tc_eop.push_back(eop);
        tc_cat.push_back(cat);
        first_idx.push_back(0);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [word_w-1:0] exp,
                              input logic [word_w-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_w-1:0] exp,
                              input logic [addr_w-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_byte(input string name, input logic [check_w-1:0] exp,
                              input logic [check_w-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    function automatic logic [addr_w-1:0] global_addr(input int page);
        return {bank_w'(tc_bank), page_w'(page)};
    endfunction

    // xor of the eight words and then high byte against low byte
    function automatic logic [check_w-1:0] expected_check(input int page);
        logic [word_w-1:0] fold;
        fold = '0;
        for (int w = 0; w < words_per_page; w++) begin
            fold = fold ^ mem_model[page * words_per_page + w];
        end
        return fold[15:8] ^ fold[7:0];
    endfunction

    task automatic wait_list_ready();
        int cycles;
        cycles = 0;
        while (!list_ready) begin
            if (cycles == 3000) begin
                abort_run("timeout: list_ready did not rise after reset");
            end
            @(posedge clk);
            #10;
            cycles++;
        end
    endtask

    // one classic cycle with the ack expected one clock after the strobe
    task automatic wb_access(input reg_addr_e adr, input logic we, input logic [word_w-1:0] wdata,
                             output logic [word_w-1:0] rdata);
        int cycles;
        @(posedge clk);
        #10;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        cycles   = 0;
        do begin
            @(posedge clk);
            #10;
            cycles++;
            if (cycles > 16) begin
                abort_run("timeout: wb_ack did not arrive");
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        check_count("wb_ack latency", 1, cycles);
    endtask

    task automatic reg_check(input string name, input reg_addr_e adr, input int exp);
        logic [word_w-1:0] rdata;
        wb_access(adr, 1'b0, '0, rdata);
        check_count(name, exp, int'(rdata));
    endtask

    // free count on the port and in the registers plus the threshold flag
    task automatic check_state(input string tag);
        check_count({tag, " free_space"}, model_free, int'(free_space));
        reg_check({tag, " reg_free"}, reg_free, model_free);
        reg_check({tag, " reg_pkt_count"}, reg_pkt_count, model_pkts);
        check_count({tag, " almost_full"}, int'(model_free < tc_low_water), int'(almost_full));
    endtask

    task automatic send_packet(input int idx, input int pass);
        int                n_words;
        int                first;
        int                page;
        int                pos;
        string             name;
        logic [word_w-1:0] word;
        name    = $sformatf("%s pass %0d", tc_name[idx], pass);
        n_words = (tc_pages[idx] - 1) * words_per_page + tc_eop[idx] + 1;
        first   = alloc_log.size();
        first_idx[idx] = first;
        for (int k = 0; k < tc_pages[idx]; k++) begin
            alloc_log.push_back(free_q.pop_front());
        end
        // links between pages of this packet and none out of the tail
        for (int k = 0; k < tc_pages[idx] - 1; k++) begin
            jump_model[alloc_log[first + k]] = global_addr(alloc_log[first + k + 1]);
            jump_known[alloc_log[first + k]] = 1'b1;
        end
        // words past eop stay stale in the sram and count as zero for the check byte
        page = alloc_log[first + tc_pages[idx] - 1];
        for (int w = tc_eop[idx] + 1; w < words_per_page; w++) begin
            mem_model[page * words_per_page + w]  = '0;
            word_known[page * words_per_page + w] = 1'b0;
        end
        for (int j = 0; j <= n_words + 2; j++) begin
            @(posedge clk);
            #10;
            check_count({name, " join_req"}, int'(j == 1), int'(join_req));
            if (j == 1) begin
                check_word({name, " join_dest"}, word_w'(tc_dest[idx]), word_w'(join_dest));
                check_word({name, " join_prior"}, word_w'(tc_prior[idx]), word_w'(join_prior));
                check_addr({name, " join_head"}, global_addr(alloc_log[first]), join_head);
                check_addr({name, " join_tail"}, global_addr(page), join_tail);
            end
            if (j < n_words) begin
                word = 16'($urandom);
                if (j == 0) begin
                    word[dest_lsb +: dest_w]   = dest_w'(tc_dest[idx]);
                    word[prior_lsb +: prior_w] = prior_w'(tc_prior[idx]);
                    word[len_lsb +: len_w]     = len_w'(tc_pages[idx] - 1);
                end
                pos = alloc_log[first + j / words_per_page] * words_per_page;
                pos = pos + j % words_per_page;
                mem_model[pos]  = word;
                word_known[pos] = 1'b1;
                wr_vld  = 1'b1;
                wr_data = word;
                wr_eop  = (j == n_words - 1);
            end else begin
                wr_vld  = 1'b0;
                wr_data = '0;
                wr_eop  = 1'b0;
            end
        end
        model_free = model_free - tc_pages[idx];
        model_pkts++;
    endtask

    // queue manager splice so the tail page of a points at the head of b
    task automatic apply_cat(input int a, input int b);
        int a_tail;
        int b_head;
        a_tail = alloc_log[first_idx[a] + tc_pages[a] - 1];
        b_head = alloc_log[first_idx[b]];
        @(posedge clk);
        #10;
        cat_en   = 1'b1;
        cat_head = page_w'(a_tail);
        cat_tail = global_addr(b_head);
        @(posedge clk);
        #10;
        cat_en = 1'b0;
        jump_model[a_tail] = global_addr(b_head);
        jump_known[a_tail] = 1'b1;
    endtask

    task automatic read_page(input string name, input int page);
        int cycles;
        int base;
        base = page * words_per_page;
        @(posedge clk);
        #10;
        rd_start = 1'b1;
        rd_page  = page_w'(page);
        @(posedge clk);
        #10;
        rd_start = 1'b0;
        // page returns to the back of the list
        free_q.push_back(page);
        model_free++;
        cycles = 0;
        while (!rd_vld) begin
            if (cycles == 16) begin
                abort_run("timeout: rd_vld did not rise after rd_start");
            end
            @(posedge clk);
            #10;
            cycles++;
        end
        check_count({name, " read latency"}, 0, cycles);
        if (jump_known[page]) begin
            check_addr({name, " rd_next_page"}, jump_model[page], rd_next_page);
        end
        check_byte({name, " rd_check"}, expected_check(page), rd_check);
        for (int w = 0; w < words_per_page; w++) begin
            if (!rd_vld) begin
                abort_run($sformatf("%s: rd_vld dropped before word %0d", name, w));
            end
            if (word_known[base + w]) begin
                check_word($sformatf("%s word %0d", name, w), mem_model[base + w], rd_data);
            end
            @(posedge clk);
            #10;
        end
        if (rd_vld) begin
            abort_run($sformatf("%s: rd_vld stayed high after eight words", name));
        end
    endtask

    initial begin
        int unsigned       seed_val;
        logic [word_w-1:0] rdata;
        seed_val = $urandom(32'h9127_dbd4);
        rst_n    = 1'b0;
        wr_vld   = 1'b0;
        wr_data  = '0;
        wr_eop   = 1'b0;
        cat_en   = 1'b0;
        cat_head = '0;
        cat_tail = '0;
        rd_start = 1'b0;
        rd_page  = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;

        // name, dest, prior, pages, eop position in last page, splice target
        add_entry("hdr_only",   1,  0, 1,  0, -1);
        add_entry("short_page", 5,  2, 1,  4, -1);
        add_entry("three_full", 9,  7, 3,  7, -1);
        add_entry("cat_a",      2,  3, 2,  2,  4);
        add_entry("cat_b",      14, 1, 4,  5, -1);
        add_entry("max_len",    15, 6, 64, 7, -1);

        mem_model  = new[num_pages * words_per_page];
        word_known = new[num_pages * words_per_page];
        jump_model = new[num_pages];
        jump_known = new[num_pages];
        for (int p = 0; p < num_pages; p++) begin
            free_q.push_back(p);
        end
        model_free = num_pages - 1;
        model_pkts = 0;

        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;

        wait_list_ready();
        check_count("free_space after fill", model_free, int'(free_space));
        wb_access(reg_ctrl, 1'b1, word_w'(tc_bank), rdata);
        wb_access(reg_low_water, 1'b1, word_w'(tc_low_water), rdata);
        // write to a read-only offset has no effect
        wb_access(reg_free, 1'b1, 16'h0005, rdata);
        reg_check("bank index readback", reg_ctrl, tc_bank);
        reg_check("low water readback", reg_low_water, tc_low_water);
        check_state("after reset");

        for (int pass = 0; pass < n_passes; pass++) begin
            for (int i = 0; i < tc_name.size(); i++) begin
                send_packet(i, pass);
            end
            check_state($sformatf("pass %0d writes", pass));
            for (int i = 0; i < tc_name.size(); i++) begin
                if (tc_cat[i] >= 0) begin
                    apply_cat(i, tc_cat[i]);
                end
            end
            for (int i = 0; i < tc_name.size(); i++) begin
                for (int k = 0; k < tc_pages[i]; k++) begin
                    read_page($sformatf("%s pass %0d page %0d", tc_name[i], pass, k),
                              alloc_log[first_idx[i] + k]);
                end
            end
            check_state($sformatf("pass %0d reads", pass));
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* sources.f */
src/buf_pkg.sv
src/pkt_pkg.sv
src/page_free_list.sv
src/page_check_gen.sv
src/buf_regs.sv
src/packet_buffer.sv
src/buf_top.sv
verification/buf_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the packet buffer testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -j 0 -f sources.f --top-module buf_tb -o buf_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/buf_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
